//--- logic/bus_map_pkg.sv
`default_nettype none

// bus widths, bus bundles and the apple-1 memory map
package bus_map_pkg;

	typedef logic [15:0] bus_addr_t; // 6502 address
	typedef logic [7:0]  bus_data_t; // 6502 data byte

	// cpu side of the bus, as presented by the 6502 core
	typedef struct packed {
		bus_addr_t addr;
		bus_data_t wdata;
		logic      wr;    // write level, qualified later by cpu_clken
	} cpu_bus_t;

	// loader port, one byte per strobe
	typedef struct packed {
		logic      active; // a download is running
		logic      strobe; // write strobe
		bus_addr_t addr;
		bus_data_t data;
	} loader_bus_t;

	typedef struct packed {
		logic low_ram;
		logic aci;
		logic basic;
		logic rom;
	} chip_select_t;

	// memory map bounds
	localparam int unsigned LOW_RAM_LAST  = 'hBFFF;
	localparam int unsigned ACI_FIRST     = 'hC000;
	localparam int unsigned ACI_LAST      = 'hC1FF;
	localparam int unsigned ACI_ROM_FIRST = 'hC100; // rom half of the aci window
	localparam int unsigned BASIC_FIRST   = 'hE000;
	localparam int unsigned BASIC_LAST    = 'hEFFF;
	localparam int unsigned ROM_FIRST     = 'hFF00; // wozmon

	// array sizes in bytes
	localparam int unsigned LOW_RAM_SIZE = LOW_RAM_LAST + 1;
	localparam int unsigned BASIC_SIZE   = BASIC_LAST - BASIC_FIRST + 1;
	localparam int unsigned ROM_SIZE     = 'h10000 - ROM_FIRST;
	localparam int unsigned ACI_ROM_SIZE = ACI_LAST - ACI_ROM_FIRST + 1;

endpackage

`default_nettype wire

//--- logic/timing_pkg.sv
`default_nettype none

// clock enable ratios and the audio sample format
package timing_pkg;

	// sys_clock runs at cpu x 7 x 8
	localparam int unsigned CPU_CLOCK_DIVIDER   = 56;
	localparam int unsigned PIXEL_CLOCK_DIVIDER = 8;

	// sigma-delta input width
	localparam int unsigned DAC_WIDTH = 16;

	typedef logic [DAC_WIDTH-1:0] dac_sample_t; // unsigned sample, msb = half scale

endpackage

`default_nettype wire

//--- logic/clock_reset_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_reset_gen (
	input  logic sys_clock,
	input  logic rst_n_i,
	input  logic loader_active_i,  // download in progress, cpu must stall
	input  logic menu_reset_i,
	input  logic reset_button_i,
	input  logic reset_key_i,      // keyboard reset key, level
	output logic cpu_clken_o,
	output logic pixel_clken_o,
	output logic system_reset_o
);

	localparam int unsigned CPU_CNT_W   = $clog2(timing_pkg::CPU_CLOCK_DIVIDER);
	localparam int unsigned PIXEL_CNT_W = $clog2(timing_pkg::PIXEL_CLOCK_DIVIDER);

	logic [CPU_CNT_W-1:0]   cpu_count;
	logic [PIXEL_CNT_W-1:0] pixel_count;
	logic                   reset_key_q;  // previous key level
	logic                   reset_key_edge;

	// free running dividers, the enable is the last count of each period
	always_ff @(posedge sys_clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cpu_count   <= '0;
			pixel_count <= '0;
		end else begin
			if (cpu_count == CPU_CNT_W'(timing_pkg::CPU_CLOCK_DIVIDER - 1))
				cpu_count <= '0;
			else
				cpu_count <= cpu_count + 1'b1;
			if (pixel_count == PIXEL_CNT_W'(timing_pkg::PIXEL_CLOCK_DIVIDER - 1))
				pixel_count <= '0;
			else
				pixel_count <= pixel_count + 1'b1;
		end
	end

	// cpu is frozen while the loader owns memory
	assign cpu_clken_o   = (cpu_count == CPU_CNT_W'(timing_pkg::CPU_CLOCK_DIVIDER - 1))
		&& !loader_active_i;
	assign pixel_clken_o = (pixel_count == PIXEL_CNT_W'(timing_pkg::PIXEL_CLOCK_DIVIDER - 1));

	// only the key press resets, a held key would otherwise keep the machine in reset
	assign reset_key_edge = reset_key_i && !reset_key_q;

	always_ff @(posedge sys_clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			reset_key_q    <= 1'b0;
			system_reset_o <= 1'b1; // machine held in reset with the fpga
		end else begin
			reset_key_q    <= reset_key_i;
			system_reset_o <= menu_reset_i | reset_button_i | reset_key_edge;
		end
	end

endmodule

`default_nettype wire

//--- logic/bus_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module bus_decoder (
	input  logic                      sys_clock,
	input  logic                      rst_n_i,
	input  bus_map_pkg::cpu_bus_t     cpu_bus_i,
	input  bus_map_pkg::loader_bus_t  loader_i,
	input  logic                      cpu_clken_i,
	output bus_map_pkg::bus_addr_t    bus_addr_o,
	output bus_map_pkg::bus_data_t    bus_wdata_o,
	output logic                      bus_wr_o,
	output logic                      loader_wr_o,   // write comes from the loader
	output bus_map_pkg::chip_select_t select_o,
	input  bus_map_pkg::bus_data_t    memory_rdata_i,
	input  bus_map_pkg::bus_data_t    aci_rdata_i,
	output bus_map_pkg::bus_data_t    cpu_rdata_o
);

	logic                      loader_owns;
	bus_map_pkg::chip_select_t select_q; // select of the previous cycle, matches read data

	// loader strobe takes the bus for that cycle, cpu has it otherwise
	assign loader_owns = loader_i.active && loader_i.strobe;

	always_comb begin
		if (loader_owns) begin
			bus_addr_o  = loader_i.addr;
			bus_wdata_o = loader_i.data;
			bus_wr_o    = 1'b1;
		end else begin
			bus_addr_o  = cpu_bus_i.addr;
			bus_wdata_o = cpu_bus_i.wdata;
			bus_wr_o    = cpu_bus_i.wr && cpu_clken_i; // cpu writes land on phi2 only
		end
	end

	assign loader_wr_o = loader_owns;

	// address decode
	always_comb begin
		select_o.low_ram = 32'(bus_addr_o) <= bus_map_pkg::LOW_RAM_LAST;
		select_o.aci     = 32'(bus_addr_o) >= bus_map_pkg::ACI_FIRST
			&& 32'(bus_addr_o) <= bus_map_pkg::ACI_LAST;
		select_o.basic   = 32'(bus_addr_o) >= bus_map_pkg::BASIC_FIRST
			&& 32'(bus_addr_o) <= bus_map_pkg::BASIC_LAST;
		select_o.rom     = 32'(bus_addr_o) >= bus_map_pkg::ROM_FIRST;
	end

	always_ff @(posedge sys_clock or negedge rst_n_i) begin
		if (!rst_n_i)
			select_q <= '0;
		else
			select_q <= select_o;
	end

	// read mux, holes in the map read as zero
	always_comb begin
		if (select_q.aci)
			cpu_rdata_o = aci_rdata_i;
		else if (select_q.low_ram || select_q.basic || select_q.rom)
			cpu_rdata_o = memory_rdata_i;
		else
			cpu_rdata_o = '0;
	end

endmodule

`default_nettype wire

//--- logic/system_memory.sv
`timescale 1ns/1ns
`default_nettype none

module system_memory (
	input  logic                      sys_clock,
	input  bus_map_pkg::bus_addr_t    bus_addr_i,
	input  bus_map_pkg::bus_data_t    bus_wdata_i,
	input  logic                      bus_wr_i,
	input  logic                      loader_wr_i,
	input  bus_map_pkg::chip_select_t select_i,
	output bus_map_pkg::bus_data_t    rdata_o
);

	localparam int unsigned BASIC_AW = $clog2(bus_map_pkg::BASIC_SIZE);
	localparam int unsigned ROM_AW   = $clog2(bus_map_pkg::ROM_SIZE);

	bus_map_pkg::bus_data_t low_ram [bus_map_pkg::LOW_RAM_SIZE]; // 0x0000-0xbfff
	bus_map_pkg::bus_data_t basic_ram [bus_map_pkg::BASIC_SIZE];  // 0xe000-0xefff
	bus_map_pkg::bus_data_t monitor_rom [bus_map_pkg::ROM_SIZE];  // 0xff00-0xffff

	logic [BASIC_AW-1:0] basic_index;
	logic [ROM_AW-1:0]   rom_index;

	bus_map_pkg::bus_data_t low_q;
	bus_map_pkg::bus_data_t basic_q;
	bus_map_pkg::bus_data_t rom_q;
	logic                   basic_sel_q;
	logic                   rom_sel_q;

	assign basic_index = bus_addr_i[BASIC_AW-1:0];
	assign rom_index   = bus_addr_i[ROM_AW-1:0];

	// low ram, whole address is the index
	always_ff @(posedge sys_clock) begin
		if (bus_wr_i && select_i.low_ram)
			low_ram[bus_addr_i] <= bus_wdata_i;
		low_q <= low_ram[bus_addr_i];
	end

	// basic lives in ram so it can be loaded
	always_ff @(posedge sys_clock) begin
		if (bus_wr_i && select_i.basic)
			basic_ram[basic_index] <= bus_wdata_i;
		basic_q <= basic_ram[basic_index];
	end

	// monitor rom, writable by the loader only
	always_ff @(posedge sys_clock) begin
		if (bus_wr_i && loader_wr_i && select_i.rom)
			monitor_rom[rom_index] <= bus_wdata_i;
		rom_q <= monitor_rom[rom_index];
	end

	// selects delayed with the array outputs
	always_ff @(posedge sys_clock) begin
		basic_sel_q <= select_i.basic;
		rom_sel_q   <= select_i.rom;
	end

	always_comb begin
		if (rom_sel_q)
			rdata_o = rom_q;
		else if (basic_sel_q)
			rdata_o = basic_q;
		else
			rdata_o = low_q;  // decoder zeroes unmapped reads
	end

endmodule

`default_nettype wire

//--- logic/cassette_interface.sv
`timescale 1ns/1ns
`default_nettype none

module cassette_interface (
	input  logic                   sys_clock,
	input  logic                   rst_n_i,
	input  bus_map_pkg::bus_addr_t bus_addr_i,
	input  bus_map_pkg::bus_data_t bus_wdata_i,
	input  logic                   bus_wr_i,
	input  logic                   loader_wr_i,
	input  logic                   aci_select_i,
	input  logic                   cpu_clken_i,
	input  logic                   tape_rx_i,    // raw cassette line
	output bus_map_pkg::bus_data_t rdata_o,
	output logic                   tape_in_o,
	output logic                   tape_out_o
);

	localparam int unsigned ROM_AW = $clog2(bus_map_pkg::ACI_ROM_SIZE);

	bus_map_pkg::bus_data_t aci_rom [bus_map_pkg::ACI_ROM_SIZE];

	logic [ROM_AW-1:0]      rom_index;
	logic                   rom_page;     // 0xc100-0xc1ff
	logic                   io_access;    // cpu touches 0xc0xx
	bus_map_pkg::bus_data_t rom_q;
	logic                   io_page_q;
	logic                   tape_in_q;
	logic                   tape_out_q;

	assign rom_index = bus_addr_i[ROM_AW-1:0];
	assign rom_page  = 32'(bus_addr_i) >= bus_map_pkg::ACI_ROM_FIRST;
	assign io_access = aci_select_i && !rom_page && cpu_clken_i && !loader_wr_i;

	// line is inverted by the input stage
	always_ff @(posedge sys_clock or negedge rst_n_i) begin
		if (!rst_n_i)
			tape_in_q <= 1'b0;
		else
			tape_in_q <= ~tape_rx_i;
	end

	// rom image comes in through the loader, both pages read it by low byte
	always_ff @(posedge sys_clock) begin
		if (bus_wr_i && loader_wr_i && aci_select_i && rom_page)
			aci_rom[rom_index] <= bus_wdata_i;
		rom_q     <= aci_rom[rom_index];
		io_page_q <= aci_select_i && !rom_page;
	end

	// io page reads carry the tape level in bit 0
	assign rdata_o = io_page_q ? {rom_q[7:1], tape_in_q} : rom_q;

	// any io page access flips the output line
	always_ff @(posedge sys_clock or negedge rst_n_i) begin
		if (!rst_n_i)
			tape_out_q <= 1'b0;
		else if (io_access)
			tape_out_q <= ~tape_out_q;
	end

	assign tape_in_o  = tape_in_q;
	assign tape_out_o = tape_out_q;

endmodule

`default_nettype wire

//--- logic/tape_monitor_dac.sv
`timescale 1ns/1ns
`default_nettype none

module tape_monitor_dac (
	input  logic sys_clock,
	input  logic rst_n_i,
	input  logic monitor_tape_in_i,  // 1 listens to tape in, 0 to tape out
	input  logic tape_in_i,
	input  logic tape_out_i,
	output logic audio_o             // pulse density output
);

	localparam int unsigned W = timing_pkg::DAC_WIDTH;

	logic                    tape_bit;
	timing_pkg::dac_sample_t sample;
	timing_pkg::dac_sample_t sigma_q;  // accumulator residue
	logic [W:0]              sum;      // carry out is the output bit

	assign tape_bit = monitor_tape_in_i ? tape_in_i : tape_out_i;
	assign sample   = {tape_bit, {(W-1){1'b0}}}; // half scale or silence

	assign sum = {1'b0, sigma_q} + {1'b0, sample};

	// first order sigma-delta, half scale gives 1010...
	always_ff @(posedge sys_clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sigma_q <= '0;
			audio_o <= 1'b0;
		end else begin
			sigma_q <= sum[W-1:0];
			audio_o <= sum[W];
		end
	end

endmodule

`default_nettype wire

//--- logic/apple1_system.sv
`timescale 1ns/1ns
`default_nettype none

module apple1_system (
	input  logic                     sys_clock,
	input  logic                     rst_n_i,
	input  bus_map_pkg::cpu_bus_t    cpu_bus_i,
	input  bus_map_pkg::loader_bus_t loader_i,
	output bus_map_pkg::bus_data_t   cpu_rdata_o,
	input  logic                     menu_reset_i,
	input  logic                     reset_button_i,
	input  logic                     reset_key_i,
	input  logic                     tape_monitor_in_i,
	input  logic                     tape_rx_i,
	output logic                     cpu_clken_o,
	output logic                     pixel_clken_o,
	output logic                     system_reset_o,
	output logic                     tape_out_o,
	output logic                     audio_o
);

	logic                      cpu_clken;
	bus_map_pkg::bus_addr_t    bus_addr;
	bus_map_pkg::bus_data_t    bus_wdata;
	logic                      bus_wr;
	logic                      loader_wr;
	bus_map_pkg::chip_select_t select;
	bus_map_pkg::bus_data_t    memory_rdata;
	bus_map_pkg::bus_data_t    aci_rdata;
	logic                      tape_in;
	logic                      tape_out;

	assign cpu_clken_o = cpu_clken;
	assign tape_out_o  = tape_out;

	clock_reset_gen clock_reset_gen_inst (
		.sys_clock       (sys_clock),
		.rst_n_i         (rst_n_i),
		.loader_active_i (loader_i.active),
		.menu_reset_i    (menu_reset_i),
		.reset_button_i  (reset_button_i),
		.reset_key_i     (reset_key_i),
		.cpu_clken_o     (cpu_clken),
		.pixel_clken_o   (pixel_clken_o),
		.system_reset_o  (system_reset_o)
	);

	bus_decoder bus_decoder_inst (
		.sys_clock      (sys_clock),
		.rst_n_i        (rst_n_i),
		.cpu_bus_i      (cpu_bus_i),
		.loader_i       (loader_i),
		.cpu_clken_i    (cpu_clken),
		.bus_addr_o     (bus_addr),
		.bus_wdata_o    (bus_wdata),
		.bus_wr_o       (bus_wr),
		.loader_wr_o    (loader_wr),
		.select_o       (select),
		.memory_rdata_i (memory_rdata),
		.aci_rdata_i    (aci_rdata),
		.cpu_rdata_o    (cpu_rdata_o)
	);

	system_memory system_memory_inst (
		.sys_clock   (sys_clock),
		.bus_addr_i  (bus_addr),
		.bus_wdata_i (bus_wdata),
		.bus_wr_i    (bus_wr),
		.loader_wr_i (loader_wr),
		.select_i    (select),
		.rdata_o     (memory_rdata)
	);

	cassette_interface cassette_interface_inst (
		.sys_clock    (sys_clock),
		.rst_n_i      (rst_n_i),
		.bus_addr_i   (bus_addr),
		.bus_wdata_i  (bus_wdata),
		.bus_wr_i     (bus_wr),
		.loader_wr_i  (loader_wr),
		.aci_select_i (select.aci),
		.cpu_clken_i  (cpu_clken),
		.tape_rx_i    (tape_rx_i),
		.rdata_o      (aci_rdata),
		.tape_in_o    (tape_in),
		.tape_out_o   (tape_out)
	);

	tape_monitor_dac tape_monitor_dac_inst (
		.sys_clock         (sys_clock),
		.rst_n_i           (rst_n_i),
		.monitor_tape_in_i (tape_monitor_in_i),
		.tape_in_i         (tape_in),
		.tape_out_i        (tape_out),
		.audio_o           (audio_o)
	);

endmodule

`default_nettype wire

//--- include/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

logic [7:0] ref_mem [0:65535]; // expected contents of every mapped byte

// step to the drive point of the next cycle
task automatic next_cycle();
	@(posedge sys_clock);
	#5;
endtask

function automatic bit is_ram(input logic [15:0] addr);
	return addr <= bus_map_pkg::LOW_RAM_LAST
		|| (addr >= bus_map_pkg::BASIC_FIRST && addr <= bus_map_pkg::BASIC_LAST);
endfunction

function automatic void model_loader_write(input logic [15:0] addr, input logic [7:0] data);
	if (is_ram(addr) || addr >= bus_map_pkg::ROM_FIRST
		|| (addr >= bus_map_pkg::ACI_ROM_FIRST && addr <= bus_map_pkg::ACI_LAST))
		ref_mem[addr] = data;
endfunction

// roms ignore the cpu
function automatic void model_cpu_write(input logic [15:0] addr, input logic [7:0] data);
	if (is_ram(addr))
		ref_mem[addr] = data;
endfunction

function automatic logic [7:0] expected_read(input logic [15:0] addr);
	logic [7:0] aci_byte;
	aci_byte = ref_mem[{8'hC1, addr[7:0]}]; // both aci pages index the rom by low byte
	if (is_ram(addr) || addr >= bus_map_pkg::ROM_FIRST)
		return ref_mem[addr];
	if (addr >= bus_map_pkg::ACI_ROM_FIRST && addr <= bus_map_pkg::ACI_LAST)
		return aci_byte;
	if (addr >= bus_map_pkg::ACI_FIRST && addr < bus_map_pkg::ACI_ROM_FIRST)
		return {aci_byte[7:1], ~tape_rx}; // tape level replaces bit 0
	return 8'h00; // holes in the map
endfunction

// hold the write until a cpu enable cycle takes it
task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
	cpu_bus.addr  = addr;
	cpu_bus.wdata = data;
	cpu_bus.wr    = 1'b1;
	@(negedge sys_clock);
	while (!cpu_clken)
		@(negedge sys_clock);
	next_cycle(); // write lands on this edge
	cpu_bus = '0;
	model_cpu_write(addr, data);
endtask

task automatic cpu_read_check(input logic [15:0] addr);
	logic [7:0] expected;
	cpu_bus      = '0;
	cpu_bus.addr = addr;
	expected     = expected_read(addr);
	next_cycle();
	cpu_bus = '0; // address moves on so only the registered byte can match
	@(negedge sys_clock); // data one cycle after the address
	assert (cpu_rdata === expected) else
		report_mismatch($sformatf("read of %h returned %h, expected %h",
			addr, cpu_rdata, expected));
	next_cycle();
endtask

task automatic loader_write(input logic [15:0] addr, input logic [7:0] data);
	loader.strobe = 1'b1;
	loader.addr   = addr;
	loader.data   = data;
	next_cycle();
	loader.strobe = 1'b0;
	model_loader_write(addr, data);
endtask

`endif

//--- bench/apple1_system_tb.sv
`timescale 1ns/1ns
`default_nettype none

module apple1_system_tb;

	localparam int unsigned CLOCK_PERIOD    = 40;
	localparam int unsigned TRANSFERS       = 1200; // loader bytes plus cpu reads and writes
	localparam int unsigned WATCHDOG_CYCLES = TRANSFERS * timing_pkg::CPU_CLOCK_DIVIDER;

	logic                     sys_clock = 1'b0;
	logic                     rst_n = 1'b0;
	bus_map_pkg::cpu_bus_t    cpu_bus;
	bus_map_pkg::loader_bus_t loader;
	bus_map_pkg::bus_data_t   cpu_rdata;
	logic                     menu_reset, reset_button, reset_key;
	logic                     tape_monitor_in, tape_rx;
	logic                     cpu_clken, pixel_clken, system_reset, tape_out, audio;
	int                       seed;

	// checker state sampled on the falling edge
	int          cpu_phase, pixel_phase;
	bit          cpu_locked, pixel_locked;
	logic        exp_reset = 1'b1;
	logic        key_prev, exp_tape_out, tape_in_exp, audio_source, source_prev;
	bit          source_valid;
	int          ones_run;   // cycles the monitored source has been 1
	logic [63:0] audio_hist;

	always #(CLOCK_PERIOD / 2) sys_clock = ~sys_clock;

	apple1_system apple1_system_inst (
		.sys_clock         (sys_clock),
		.rst_n_i           (rst_n),
		.cpu_bus_i         (cpu_bus),
		.loader_i          (loader),
		.cpu_rdata_o       (cpu_rdata),
		.menu_reset_i      (menu_reset),
		.reset_button_i    (reset_button),
		.reset_key_i       (reset_key),
		.tape_monitor_in_i (tape_monitor_in),
		.tape_rx_i         (tape_rx),
		.cpu_clken_o       (cpu_clken),
		.pixel_clken_o     (pixel_clken),
		.system_reset_o    (system_reset),
		.tape_out_o        (tape_out),
		.audio_o           (audio)
	);

	`include "tb_bus_tasks.svh"

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("FAILED at %0t: %s", $time, msg));
	endtask

	function automatic int count_ones(input logic [63:0] bits);
		int n;
		n = 0;
		for (int i = 0; i < 64; i++)
			n += bits[i];
		return n;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// phase of the enable cadence locks to the first pulse after reset
	always @(negedge sys_clock) begin
		if (!rst_n) begin
			cpu_locked   = 1'b0;
			pixel_locked = 1'b0;
		end else begin
			if (cpu_locked) begin
				cpu_phase = (cpu_phase + 1) % timing_pkg::CPU_CLOCK_DIVIDER;
				assert (cpu_clken === (cpu_phase == 0 && !loader.active)) else
					report_mismatch("cpu_clken_o off its 56 cycle cadence");
			end else if (cpu_clken) begin
				cpu_locked = 1'b1;
				cpu_phase  = 0;
			end
			if (pixel_locked) begin
				pixel_phase = (pixel_phase + 1) % timing_pkg::PIXEL_CLOCK_DIVIDER;
				assert (pixel_clken === (pixel_phase == 0)) else
					report_mismatch("pixel_clken_o off its 8 cycle cadence");
			end else if (pixel_clken) begin
				pixel_locked = 1'b1;
				pixel_phase  = 0;
			end
			assert (!(cpu_clken && loader.active)) else
				report_mismatch("cpu_clken_o pulsed during a download");
		end
	end

	// reset sources land one cycle later and the key only on its rising edge
	always @(negedge sys_clock) begin
		assert (system_reset === exp_reset) else
			report_mismatch("system_reset_o does not follow its sources");
		if (!rst_n) begin
			assert (!cpu_clken && !pixel_clken && !tape_out && !audio) else
				report_mismatch("outputs not idle during reset");
			exp_reset = 1'b1;
			key_prev  = 1'b0;
		end else begin
			exp_reset = menu_reset || reset_button || (reset_key && !key_prev);
			key_prev  = reset_key;
		end
	end

	// tape out flips once per accepted cpu access to the io page
	always @(negedge sys_clock) begin
		if (!rst_n)
			exp_tape_out = 1'b0;
		else begin
			assert (tape_out === exp_tape_out) else
				report_mismatch("tape_out_o did not toggle with io page accesses");
			if (cpu_clken && !(loader.active && loader.strobe)
				&& cpu_bus.addr >= bus_map_pkg::ACI_FIRST
				&& cpu_bus.addr < bus_map_pkg::ACI_ROM_FIRST)
				exp_tape_out = !exp_tape_out;
		end
	end

	// a full window of ones gives exactly half density on audio
	always @(negedge sys_clock) begin
		if (!rst_n) begin
			tape_in_exp  = 1'b0;
			source_valid = 1'b0;
			ones_run     = 0;
			audio_hist   = '0;
		end else begin
			audio_hist = {audio_hist[62:0], audio};
			if (source_valid && !source_prev) begin
				assert (audio === 1'b0) else
					report_mismatch("audio_o pulsed while the tape source was 0");
			end
			if (ones_run >= 64) begin
				assert (count_ones(audio_hist) == 32) else
					report_mismatch("audio_o not 32 ones in a 64 cycle window");
			end
			audio_source = tape_monitor_in ? tape_in_exp : tape_out;
			ones_run     = audio_source ? ones_run + 1 : 0;
			source_prev  = audio_source;
			source_valid = 1'b1;
			tape_in_exp  = ~tape_rx;  // latched one cycle later
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		abort_run("watchdog expired, the test sequence did not finish in time");
	end

	initial begin
		logic [15:0] addr;
		logic [15:0] written [$];
		seed            = 19;
		rst_n           = 1'b0;
		cpu_bus         = '0;
		loader          = '0;
		menu_reset      = 1'b0;
		reset_button    = 1'b0;
		reset_key       = 1'b0;
		tape_monitor_in = 1'b1;
		tape_rx         = 1'b1;
		repeat (10) @(posedge sys_clock);
		#5;
		rst_n = 1'b1;

		// rom images go in through the loader while the cpu is frozen
		loader.active = 1'b1;
		repeat (120) next_cycle();
		for (int i = 0; i < 256; i++)
			loader_write({8'hFF, i[7:0]}, random_byte());
		for (int i = 0; i < 256; i++)
			loader_write({8'hC1, i[7:0]}, random_byte());
		loader.active = 1'b0;
		for (int i = 0; i < 256; i++)
			cpu_read_check({8'hFF, i[7:0]});
		for (int i = 0; i < 256; i++)
			cpu_read_check({8'hC1, i[7:0]});
		cpu_write(16'hFF10, ~ref_mem[16'hFF10]); // roms ignore the cpu
		cpu_read_check(16'hFF10);
		cpu_write(16'hC110, ~ref_mem[16'hC110]);
		cpu_read_check(16'hC110);

		// low ram and basic ram
		for (int i = 0; i < 12; i++) begin
			addr = {random_byte(), random_byte()} % 16'hC000;
			written.push_back(addr);
			cpu_write(addr, random_byte());
			addr        = {random_byte(), random_byte()};
			addr[15:12] = 4'hE; // basic ram window
			written.push_back(addr);
			cpu_write(addr, random_byte());
		end
		foreach (written[i])
			cpu_read_check(written[i]);
		cpu_read_check(16'hC200);
		cpu_read_check(16'hDFFF);
		cpu_read_check(16'hF000);
		cpu_read_check(16'hFEFF);

		// loader strobe against a pending cpu write to the same byte
		cpu_bus.addr  = 16'h0300;
		cpu_bus.wdata = 8'h5A;
		cpu_bus.wr    = 1'b1;
		loader.active = 1'b1;
		loader_write(16'h0300, 8'hA5);
		cpu_bus       = '0;
		loader.active = 1'b0;
		cpu_read_check(16'h0300);

		// io page reads carry the inverted tape line
		tape_rx = 1'b0;
		repeat (2) next_cycle();
		for (int i = 0; i < 8; i++)
			cpu_read_check({8'hC0, random_byte()});
		tape_rx = 1'b1;
		repeat (2) next_cycle();
		for (int i = 0; i < 8; i++)
			cpu_read_check({8'hC0, random_byte()});
		for (int i = 0; i < 4; i++)
			cpu_write({8'hC0, random_byte()}, random_byte());

		// reset sources
		reset_key = 1'b1;
		repeat (6) next_cycle();
		reset_key = 1'b0;
		repeat (2) next_cycle();
		menu_reset = 1'b1;
		repeat (4) next_cycle();
		menu_reset   = 1'b0;
		reset_button = 1'b1;
		repeat (4) next_cycle();
		reset_button = 1'b0;
		repeat (2) next_cycle();

		// tape monitor on tape in and then on tape out
		tape_rx = 1'b0;
		repeat (150) next_cycle();
		tape_rx = 1'b1;
		repeat (80) next_cycle();
		tape_monitor_in = 1'b0;
		if (!tape_out)
			cpu_write(16'hC000, 8'h00);
		repeat (150) next_cycle();
		cpu_write(16'hC000, 8'h00);
		repeat (80) next_cycle();

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
logic/bus_map_pkg.sv
logic/timing_pkg.sv
logic/clock_reset_gen.sv
logic/bus_decoder.sv
logic/system_memory.sv
logic/cassette_interface.sv
logic/tape_monitor_dac.sv
logic/apple1_system.sv
bench/apple1_system_tb.sv

//--- Bender.yml
package:
  name: apple1_system

sources:
  - files:
      - logic/bus_map_pkg.sv
      - logic/timing_pkg.sv
      - logic/clock_reset_gen.sv
      - logic/bus_decoder.sv
      - logic/system_memory.sv
      - logic/cassette_interface.sv
      - logic/tape_monitor_dac.sv
      - logic/apple1_system.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/apple1_system_tb.sv
